//--- verilog/probe_params.svh
//------------------------------
// logic probe build parameters
// channel width, trace depth, bit period
//------------------------------

`ifndef PROBE_PARAMS_SVH
`define PROBE_PARAMS_SVH

// number of probe channels per trace word
// must be a multiple of 8, one byte lane per 8 channels
`define PROBE_CHANNELS 32

// number of trace words in the memory
// must be a power of two
`define PROBE_DEPTH 16

// clock cycles per serial bit
// scaled down for simulation, a real line would use clock / baud
`define PROBE_BIT_CYCLES 8

`endif

//--- verilog/probe_pkg.sv
//------------------------------
// logic probe shared types
// byte type and state encodings
//------------------------------

package probe_pkg;

  // one byte on its way from trace memory to the serial line
  typedef logic [7:0] probe_byte_t;

  // capture control: waiting for trigger, filling, done filling
  typedef enum logic [1:0] {
    cap_idle,
    cap_armed,
    cap_full
  } capture_state_t;

  // read-out sequencer
  typedef enum logic [1:0] {
    rd_wait_full,
    rd_wait_ready,
    rd_write,
    rd_done
  } readout_state_t;

  // serial framing
  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

endpackage

//--- verilog/trace_capture.sv
//------------------------------
// trace capture
// trigger/sample control and trace memory with byte read port
//------------------------------

`timescale 1ns/100ps
`include "probe_params.svh"

module trace_capture (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   trigger,
  input  logic                   sample,
  input  logic [`PROBE_CHANNELS-1:0] channels,
  input  logic [$clog2(`PROBE_DEPTH * `PROBE_CHANNELS / 8)-1:0] rd_addr,
  output logic                   full,
  output probe_pkg::probe_byte_t rd_data
);

  localparam int BYTES  = `PROBE_CHANNELS / 8;
  localparam int WORD_W = $clog2(`PROBE_DEPTH);
  localparam int LANE_W = $clog2(BYTES);
  localparam int ADDR_W = WORD_W + LANE_W;

  probe_pkg::capture_state_t state;

  // write pointer, next free word
  logic [WORD_W-1:0] wr_addr;

  // single port memory, shared between capture and read-out
  logic [`PROBE_CHANNELS-1:0] mem [`PROBE_DEPTH];
  logic [`PROBE_CHANNELS-1:0] mem_q;
  logic [WORD_W-1:0]          mem_addr;
  logic                       wr_en;

  // byte lane, delayed to match the registered memory output
  logic [LANE_W-1:0] lane_q;

  assign full = (state == probe_pkg::cap_full);

  // the trigger cycle itself may already carry the first sample
  assign wr_en = sample &&
                 ((state == probe_pkg::cap_armed) ||
                  ((state == probe_pkg::cap_idle) && trigger));

  // capture owns the address until full, then read-out takes over
  assign mem_addr = full ? rd_addr[ADDR_W-1:LANE_W] : wr_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= probe_pkg::cap_idle;
      wr_addr <= '0;
    end else begin
      case (state)
        probe_pkg::cap_idle: begin
          if (trigger) begin
            state <= probe_pkg::cap_armed;
            if (sample) begin
              wr_addr <= wr_addr + 1'b1;
            end
          end
        end

        probe_pkg::cap_armed: begin
          if (sample) begin
            // last word stored on this edge
            if (wr_addr == WORD_W'(`PROBE_DEPTH - 1)) begin
              state <= probe_pkg::cap_full;
            end else begin
              wr_addr <= wr_addr + 1'b1;
            end
          end
        end

        probe_pkg::cap_full: begin
          // stays here until reset, no re-arming
          state <= probe_pkg::cap_full;
        end

        default: begin
          state <= probe_pkg::cap_idle;
        end
      endcase
    end
  end

  // trace memory with registered read
  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[mem_addr] <= channels;
    end
    mem_q <= mem[mem_addr];
  end

  always_ff @(posedge clock) begin
    lane_q <= rd_addr[LANE_W-1:0];
  end

  // lane 0 is the most significant byte of the word
  assign rd_data = mem_q[8 * (BYTES - 1 - int'(lane_q)) +: 8];

endmodule

//--- verilog/trace_readout.sv
//------------------------------
// trace read-out sequencer
// walks every byte address once and feeds the transmitter
//------------------------------

`timescale 1ns/100ps
`include "probe_params.svh"

module trace_readout (
  input  logic clock,
  input  logic reset,
  input  logic full,
  input  logic ready,
  output logic [$clog2(`PROBE_DEPTH * `PROBE_CHANNELS / 8)-1:0] rd_addr,
  output logic write
);

  localparam int BYTES  = `PROBE_CHANNELS / 8;
  localparam int WORD_W = $clog2(`PROBE_DEPTH);
  localparam int LANE_W = $clog2(BYTES);

  probe_pkg::readout_state_t state;

  // byte address split into word and lane
  logic [WORD_W-1:0] word_idx;
  logic [LANE_W-1:0] lane_idx;
  logic              last_lane;
  logic              last_byte;

  assign rd_addr   = {word_idx, lane_idx};
  assign write     = (state == probe_pkg::rd_write);
  assign last_lane = (lane_idx == LANE_W'(BYTES - 1));
  assign last_byte = last_lane && (word_idx == WORD_W'(`PROBE_DEPTH - 1));

  // rd_addr is stable for at least one cycle before write,
  // which covers the registered memory read
  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= probe_pkg::rd_wait_full;
      word_idx <= '0;
      lane_idx <= '0;
    end else begin
      case (state)
        probe_pkg::rd_wait_full: begin
          if (full) begin
            state <= probe_pkg::rd_wait_ready;
          end
        end

        probe_pkg::rd_wait_ready: begin
          if (ready) begin
            state <= probe_pkg::rd_write;
          end
        end

        probe_pkg::rd_write: begin
          if (last_byte) begin
            state <= probe_pkg::rd_done;
          end else begin
            state <= probe_pkg::rd_wait_ready;
            if (last_lane) begin
              lane_idx <= '0;
              word_idx <= word_idx + 1'b1;
            end else begin
              lane_idx <= lane_idx + 1'b1;
            end
          end
        end

        default: begin
          state <= probe_pkg::rd_done;
        end
      endcase
    end
  end

endmodule

//--- verilog/uart_tx.sv
//------------------------------
// serial transmitter
// holding register plus 8N1 shifter
//------------------------------

`timescale 1ns/100ps
`include "probe_params.svh"

module uart_tx (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   write,
  input  probe_pkg::probe_byte_t data,
  output logic                   ready,
  output logic                   serial_out
);

  localparam int CNT_W = $clog2(`PROBE_BIT_CYCLES + 1);

  probe_pkg::tx_state_t state;

  // holding register
  probe_pkg::probe_byte_t hold_data;
  logic                   hold_full;

  // shifter
  probe_pkg::probe_byte_t shift;
  logic [CNT_W-1:0]       bit_cnt;
  logic [2:0]             bit_idx;
  logic                   bit_end;
  logic                   load;

  assign ready   = !hold_full;
  assign bit_end = (bit_cnt == CNT_W'(`PROBE_BIT_CYCLES - 1));

  // take the next byte when idle, or straight out of a finished stop bit
  // so consecutive frames run without a gap
  assign load = hold_full &&
                ((state == probe_pkg::tx_idle) ||
                 ((state == probe_pkg::tx_stop) && bit_end));

  // write only arrives while empty, load only while full
  always_ff @(posedge clock) begin
    if (reset) begin
      hold_full <= 1'b0;
    end else if (write) begin
      hold_full <= 1'b1;
    end else if (load) begin
      hold_full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      hold_data <= data;
    end
  end

  // data bits leave lsb first, refill with ones
  always_ff @(posedge clock) begin
    if (load) begin
      shift <= hold_data;
    end else if (bit_end &&
                 ((state == probe_pkg::tx_start) || (state == probe_pkg::tx_data))) begin
      shift <= {1'b1, shift[7:1]};
    end
  end

  // line register is driven from the framing FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= probe_pkg::tx_idle;
      bit_cnt    <= '0;
      bit_idx    <= '0;
      serial_out <= 1'b1;
    end else if (load) begin
      state      <= probe_pkg::tx_start;
      bit_cnt    <= '0;
      bit_idx    <= '0;
      serial_out <= 1'b0;
    end else if (state != probe_pkg::tx_idle) begin
      if (!bit_end) begin
        bit_cnt <= bit_cnt + 1'b1;
      end else begin
        bit_cnt <= '0;
        case (state)
          probe_pkg::tx_start: begin
            state      <= probe_pkg::tx_data;
            serial_out <= shift[0];
          end

          probe_pkg::tx_data: begin
            if (bit_idx == 3'd7) begin
              state      <= probe_pkg::tx_stop;
              serial_out <= 1'b1;
            end else begin
              bit_idx    <= bit_idx + 1'b1;
              serial_out <= shift[0];
            end
          end

          default: begin
            // end of stop bit with nothing waiting
            state <= probe_pkg::tx_idle;
          end
        endcase
      end
    end
  end

endmodule

//--- verilog/logic_probe.sv
//------------------------------
// logic probe top level
// capture, read-out and serial transmitter
//------------------------------

`timescale 1ns/100ps
`include "probe_params.svh"

module logic_probe (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       trigger,
  input  logic                       sample,
  input  logic [`PROBE_CHANNELS-1:0] channels,
  output logic                       serial_out
);

  localparam int ADDR_W = $clog2(`PROBE_DEPTH * `PROBE_CHANNELS / 8);

  logic                   full;
  logic [ADDR_W-1:0]      rd_addr;
  probe_pkg::probe_byte_t rd_data;
  logic                   write;
  logic                   ready;

  trace_capture capture0 (
    .clock    (clock),
    .reset    (reset),
    .trigger  (trigger),
    .sample   (sample),
    .channels (channels),
    .rd_addr  (rd_addr),
    .full     (full),
    .rd_data  (rd_data)
  );

  // ready from the transmitter holds the sequencer back
  trace_readout readout0 (
    .clock   (clock),
    .reset   (reset),
    .full    (full),
    .ready   (ready),
    .rd_addr (rd_addr),
    .write   (write)
  );

  uart_tx tx0 (
    .clock      (clock),
    .reset      (reset),
    .write      (write),
    .data       (rd_data),
    .ready      (ready),
    .serial_out (serial_out)
  );

endmodule

//--- tb/tb_logic_probe.sv
//------------------------------
// logic probe testbench
// table driven capture, serial frame decoder and byte checks
//------------------------------

`timescale 1ns/100ps
`include "probe_params.svh"

module tb_logic_probe;

  localparam int BYTES          = `PROBE_CHANNELS / 8;
  localparam int TOTAL_BYTES    = `PROBE_DEPTH * BYTES;
  localparam int PRE_ROWS       = 4;
  localparam int TABLE_LEN      = 33;
  localparam int FRAME_CYCLES   = 10 * `PROBE_BIT_CYCLES;
  localparam int QUIET_CYCLES   = 20 * `PROBE_BIT_CYCLES;
  localparam int TIMEOUT_CYCLES = TABLE_LEN + TOTAL_BYTES * (FRAME_CYCLES + 4) + 200;

  logic                       clock;
  logic                       reset;
  logic                       trigger;
  logic                       sample;
  logic [`PROBE_CHANNELS-1:0] channels;
  logic                       serial_out;

  // stimulus table with one row per clock cycle
  logic                       tab_trigger  [TABLE_LEN];
  logic                       tab_sample   [TABLE_LEN];
  logic [`PROBE_CHANNELS-1:0] tab_channels [TABLE_LEN];

  // bytes expected on the serial line in order
  probe_pkg::probe_byte_t expected_bytes [TOTAL_BYTES];

  integer seed;
  int     pass_count;
  int     fail_count;
  int     frame_count;
  int     cycle_count = 0;

  logic_probe dut0 (
    .clock      (clock),
    .reset      (reset),
    .trigger    (trigger),
    .sample     (sample),
    .channels   (channels),
    .serial_out (serial_out)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("error: timeout, read-out did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clock);
  endtask

  task automatic check_byte(input string name, input probe_pkg::probe_byte_t expected,
                            input probe_pkg::probe_byte_t actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, got %h", name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, got %h", name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error: %s", what);
    fail_count++;
  endtask

  task automatic end_test(input string name, input int fails_before);
    if (fail_count == fails_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed", name);
    end
  endtask

  // every pre-trigger row samples and every third row after the trigger is idle
  task automatic build_table();
    for (int r = 0; r < TABLE_LEN; r++) begin
      tab_trigger[r]  = (r == PRE_ROWS);
      tab_sample[r]   = (r <= PRE_ROWS) || (r % 3 != 0);
      tab_channels[r] = `PROBE_CHANNELS'($random(seed));
    end
  endtask

  // keep sampled rows from the trigger row on until the memory is full
  task automatic build_expected();
    logic [`PROBE_CHANNELS-1:0] words [$];
    logic [`PROBE_CHANNELS-1:0] word;
    logic                       armed;
    armed = 1'b0;
    for (int r = 0; r < TABLE_LEN; r++) begin
      if (tab_trigger[r]) begin
        armed = 1'b1;
      end
      if (armed && tab_sample[r] && (words.size() < `PROBE_DEPTH)) begin
        words.push_back(tab_channels[r]);
      end
    end
    if (words.size() != `PROBE_DEPTH) begin
      report_failure("stimulus table does not fill the trace memory");
    end
    // most significant byte of each word goes first
    for (int w = 0; w < words.size(); w++) begin
      word = words[w];
      for (int b = 0; b < BYTES; b++) begin
        expected_bytes[w * BYTES + b] = word[`PROBE_CHANNELS-1 -: 8];
        word = word << 8;
      end
    end
  endtask

  // serial decoder sampling at negedge near the middle of each bit
  initial begin : frame_decoder
    probe_pkg::probe_byte_t rx;
    int                     fails_before;
    forever begin
      @(negedge clock);
      if (!reset && serial_out === 1'b0) begin
        fails_before = fail_count;
        wait_cycles(`PROBE_BIT_CYCLES / 2);
        if (serial_out !== 1'b0) begin
          report_failure($sformatf("start bit of frame %0d is not low at mid-bit",
                                   frame_count));
        end
        for (int i = 0; i < 8; i++) begin
          wait_cycles(`PROBE_BIT_CYCLES);
          rx[i] = serial_out;
        end
        wait_cycles(`PROBE_BIT_CYCLES);
        if (serial_out !== 1'b1) begin
          report_failure($sformatf("stop bit of frame %0d is not high", frame_count));
        end
        if (frame_count < TOTAL_BYTES) begin
          check_byte($sformatf("serial_out byte %0d", frame_count),
                     expected_bytes[frame_count], rx);
        end else begin
          report_failure("extra frame sent after the last trace byte");
        end
        frame_count++;
        end_test($sformatf("frame %0d", frame_count - 1), fails_before);
      end
    end
  end

  initial begin : main_flow
    int fails_before;
    seed        = 1947;
    clock       = 1'b0;
    reset       = 1'b1;
    trigger     = 1'b0;
    sample      = 1'b0;
    channels    = '0;
    pass_count  = 0;
    fail_count  = 0;
    frame_count = 0;

    build_table();
    build_expected();

    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    fails_before = fail_count;
    check_level("serial_out after reset", 1'b1, serial_out);

    // the line must stay idle through the pre-trigger rows
    for (int r = 0; r < TABLE_LEN; r++) begin
      trigger  = tab_trigger[r];
      sample   = tab_sample[r];
      channels = tab_channels[r];
      @(negedge clock);
      if (r < PRE_ROWS) begin
        check_level("serial_out before trigger", 1'b1, serial_out);
      end
      if (r == PRE_ROWS - 1) begin
        end_test("idle before trigger", fails_before);
      end
    end
    trigger = 1'b0;
    sample  = 1'b0;

    // wait until the decoder has seen every frame
    while (frame_count < TOTAL_BYTES) begin
      @(negedge clock);
    end

    fails_before = fail_count;
    // a second trigger with a sample must not start another capture
    trigger  = 1'b1;
    sample   = 1'b1;
    channels = `PROBE_CHANNELS'($random(seed));
    @(negedge clock);
    trigger  = 1'b0;
    sample   = 1'b0;
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clock);
      check_level("serial_out after last frame", 1'b1, serial_out);
    end
    if (frame_count != TOTAL_BYTES) begin
      report_failure($sformatf("saw %0d frames instead of %0d", frame_count, TOTAL_BYTES));
    end
    end_test("quiet after read-out", fails_before);

    $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/probe_pkg.sv
verilog/trace_capture.sv
verilog/trace_readout.sv
verilog/uart_tx.sv
verilog/logic_probe.sv
tb/tb_logic_probe.sv

//--- run_sim.sh
#!/bin/sh
# build the logic probe testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module tb_logic_probe \
  -Mdir obj_dir \
  -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_logic_probe)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the pass message only when every check held
if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
